// ==== Bender.yml ====
package:
  name: led_matrix

sources:
  - include_dirs:
      - source
    files:
      - source/led_matrix_pkg.sv
      - source/serial_rx.sv
      - source/command_parser.sv
      - source/frame_buffer.sv
      - source/pixel_fetch.sv
      - source/matrix_scan.sv
      - source/led_matrix_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - bench/led_matrix_tb.sv

// ==== bench/led_matrix_tb.sv ====
// Pixels are compared only for lines written during the run; the frame buffer starts unknown
`timescale 1ns/1ps
`default_nettype none
`include "led_matrix_macros.svh"

module led_matrix_tb;

	localparam int TICKS = `LM_UART_TICKS_PER_BIT;
	localparam int PLANES = `LM_PLANES;
	localparam int LATCHES_PER_FRAME = `LM_ROW_PAIRS * `LM_PLANES;
	localparam int LINES_WRITTEN = 8;
	// Row pairs written, both halves each
	localparam logic [15:0] ROW_SET = {4'd15, 4'd9, 4'd3, 4'd0};
	// Lines, two rounds of 'B' and 'C', unknown byte, aborted line
	localparam longint BYTES_TOTAL = LINES_WRITTEN * 130 + 8 + 1 + 130;
	// Pessimistic frame, 12 cycles per column plus all on times
	localparam longint FRAME_CYCLES = `LM_ROW_PAIRS * (PLANES * (`LM_COLUMNS * 12 + 4)
		+ (`LM_OE_BASE_CYCLES << PLANES));
	// Four frame waits plus two frames of margin, 4 ns per cycle
	localparam longint LIMIT_NS = (BYTES_TOTAL * 10 * TICKS + 6 * FRAME_CYCLES) * 4;

	logic                   clk_root;
	logic                   arst_n;
	logic                   rxd;
	led_matrix_pkg::hub75_t panel;
	logic                   rx_busy;
	logic [7:0]             commands_done;

	// Reference image and settings
	logic [15:0] ref_img [2048];
	logic [31:0] known;
	logic [5:0]  ref_bright;
	logic [2:0]  ref_rgb;
	logic [7:0]  exp_done;
	logic        sending;
	logic        busy_expect;
	logic        reset_window;

	// Panel monitor state
	logic [3:0]  mon_row;
	logic [2:0]  mon_plane;
	logic [6:0]  mon_col;
	logic [2:0]  lit_plane;
	logic        pclk_d;
	logic        latch_d;
	logic        check_en;
	logic [15:0] oe_cnt;
	int          latch_count;
	int          pixel_checks;
	logic [10:0] top_idx;
	logic [10:0] bot_idx;
	logic [2:0]  exp_top;
	logic [2:0]  exp_bot;

	int errors;
	int timing_errors;

	led_matrix_top led_matrix_top_inst (
		.clk_root      (clk_root),
		.arst_n        (arst_n),
		.rxd           (rxd),
		.panel         (panel),
		.rx_busy       (rx_busy),
		.commands_done (commands_done)
	);

	initial begin
		clk_root = 1'b0;
		forever #2 clk_root = ~clk_root;
	end

	// RGB565 pixel to one plane's bits, bit 0 red
	function automatic logic [2:0] expected_bits(input logic [15:0] px, input logic [2:0] plane,
		input logic [5:0] bright, input logic [2:0] chan);
		logic [5:0] red6;
		logic [5:0] green6;
		logic [5:0] blue6;
		logic [2:0] raw;
		// Five-bit channels gain a zero LSB
		red6 = {px[15:11], 1'b0};
		green6 = px[10:5];
		blue6 = {px[4:0], 1'b0};
		raw = {blue6[plane], green6[plane], red6[plane]};
		if (!bright[plane]) begin
			raw = 3'b000;
		end
		return raw & chan;
	endfunction

	assign top_idx = {1'b0, mon_row, mon_col[5:0]};
	assign bot_idx = {1'b1, mon_row, mon_col[5:0]};
	assign exp_top = expected_bits(ref_img[top_idx], mon_plane, ref_bright, ref_rgb);
	assign exp_bot = expected_bits(ref_img[bot_idx], mon_plane, ref_bright, ref_rgb);

	task automatic value_error(input string msg);
		errors++;
		$display("Fail at %0d ns: %s", $time, msg);
	endtask

	task automatic timing_error(input string msg);
		timing_errors++;
		value_error(msg);
	endtask

	// Tracks plane and row pair by latch count, column by pixel_clk rises
	always_ff @(posedge clk_root or negedge arst_n) begin
		if (!arst_n) begin
			mon_row      <= '0;
			mon_plane    <= '0;
			mon_col      <= '0;
			lit_plane    <= '0;
			pclk_d       <= 1'b0;
			latch_d      <= 1'b0;
			check_en     <= 1'b0;
			oe_cnt       <= '0;
			latch_count  <= 0;
			pixel_checks <= 0;
		end else begin
			pclk_d <= panel.pixel_clk;
			latch_d <= panel.latch;
			oe_cnt <= panel.oe_n ? 16'd0 : oe_cnt + 16'd1;
			if (panel.pixel_clk && !pclk_d) begin
				mon_col <= mon_col + 7'd1;
				if (check_en && !sending && known[mon_row]) begin
					pixel_checks <= pixel_checks + 1;
				end
			end
			if (panel.latch && !latch_d) begin
				mon_col <= '0;
				lit_plane <= mon_plane;
				latch_count <= latch_count + 1;
				// Compare only planes fetched after the last write
				check_en <= !sending;
				if (mon_plane == 3'(PLANES - 1)) begin
					mon_plane <= '0;
					mon_row <= mon_row + 4'd1;
				end else begin
					mon_plane <= mon_plane + 3'd1;
				end
			end else if (sending) begin
				check_en <= 1'b0;
			end
		end
	end

	// Dark panel, zero count
	assert property (@(posedge clk_root) reset_window |->
		panel.oe_n && !panel.latch && !panel.pixel_clk && commands_done == 8'd0)
		else value_error("panel or command count not in reset state");

	assert property (@(posedge clk_root) disable iff (!arst_n)
		$rose(panel.pixel_clk) && check_en && !sending && known[mon_row] |->
		panel.rgb_top == exp_top)
		else value_error($sformatf("rgb_top row %0d col %0d plane %0d got %b want %b",
			$sampled(mon_row), $sampled(mon_col), $sampled(mon_plane),
			$sampled(panel.rgb_top), $sampled(exp_top)));

	assert property (@(posedge clk_root) disable iff (!arst_n)
		$rose(panel.pixel_clk) && check_en && !sending && known[{1'b1, mon_row}] |->
		panel.rgb_bot == exp_bot)
		else value_error($sformatf("rgb_bot row %0d col %0d plane %0d got %b want %b",
			$sampled(mon_row), $sampled(mon_col), $sampled(mon_plane),
			$sampled(panel.rgb_bot), $sampled(exp_bot)));

	// 64 shifts per latch, row follows the scan order
	assert property (@(posedge clk_root) disable iff (!arst_n)
		$rose(panel.latch) |-> mon_col == 7'd64 && panel.row_addr == mon_row)
		else timing_error($sformatf("latch after %0d clocks, row_addr %0d want %0d",
			$sampled(mon_col), $sampled(panel.row_addr), $sampled(mon_row)));

	// Binary weighted on time
	assert property (@(posedge clk_root) disable iff (!arst_n)
		$rose(panel.oe_n) |-> oe_cnt == 16'(`LM_OE_BASE_CYCLES << lit_plane))
		else timing_error($sformatf("plane %0d lit %0d cycles",
			$sampled(lit_plane), $sampled(oe_cnt)));

	assert property (@(posedge clk_root) disable iff (!arst_n) panel.latch |-> panel.oe_n)
		else timing_error("latch high while the row is lit");

	assert property (@(posedge clk_root) disable iff (!arst_n) busy_expect |-> rx_busy)
		else value_error("rx_busy low inside a valid command");

	assert property (@(posedge clk_root) disable iff (!arst_n) !sending |->
		commands_done == exp_done)
		else value_error($sformatf("commands_done %0d want %0d",
			$sampled(commands_done), $sampled(exp_done)));

	task automatic send_bit(input logic b);
		rxd <= b;
		repeat (TICKS) @(posedge clk_root);
	endtask

	// 8N1, LSB first
	// Busy flag spans start and data bits only
	task automatic send_byte(input logic [7:0] b, input logic busy_exp);
		busy_expect <= busy_exp;
		send_bit(1'b0);
		for (int i = 0; i < 8; i++) begin
			send_bit(b[i]);
		end
		busy_expect <= 1'b0;
		send_bit(1'b1);
	endtask

	// Last write lands before the parser goes idle
	task automatic finish_command(input int inc);
		repeat (2) @(posedge clk_root);
		while (rx_busy) begin
			@(posedge clk_root);
		end
		exp_done <= exp_done + 8'(inc);
		sending <= 1'b0;
		@(posedge clk_root);
	endtask

	// Random line, high byte of each pixel first
	task automatic send_line(input logic [4:0] line);
		logic [15:0] px;
		sending <= 1'b1;
		known[line] <= 1'b1;
		send_byte(8'h4C, 1'b0);
		send_byte({3'b000, line}, 1'b1);
		for (int c = 0; c < `LM_COLUMNS; c++) begin
			px = 16'($urandom);
			ref_img[{line, 6'(c)}] <= px;
			send_byte(px[15:8], 1'b1);
			send_byte(px[7:0], 1'b1);
		end
		finish_command(1);
	endtask

	task automatic send_setting(input logic [7:0] cmd, input logic [7:0] value);
		sending <= 1'b1;
		if (cmd == 8'h42) begin
			ref_bright <= value[5:0];
		end else begin
			ref_rgb <= value[2:0];
		end
		send_byte(cmd, 1'b0);
		send_byte(value, 1'b1);
		finish_command(1);
	endtask

	// Unknown command, then an out of range line
	task automatic send_aborts();
		sending <= 1'b1;
		send_byte(8'h5A, 1'b0);
		send_byte(8'h4C, 1'b0);
		// Line 35 aliases line 3 if only five bits were kept
		send_byte(8'd35, 1'b0);
		for (int i = 0; i < 128; i++) begin
			send_byte(8'h00, 1'b0);
		end
		finish_command(0);
	endtask

	// One full scan after checking resumes
	task automatic wait_frame();
		int target;
		target = latch_count + LATCHES_PER_FRAME + 1;
		while (latch_count < target) begin
			@(posedge clk_root);
		end
	endtask

	task automatic end_test(input int num, input string name, input int err_start);
		$display("test %0d %s: %s, %0d errors", num, name,
			(errors == err_start) ? "ok" : "failed", errors - err_start);
	endtask

	initial begin
		int err_start;
		logic [3:0] row;
		arst_n = 1'b0;
		rxd = 1'b1;
		sending = 1'b0;
		busy_expect = 1'b0;
		reset_window = 1'b0;
		known = '0;
		ref_bright = '1;
		ref_rgb = '1;
		exp_done = '0;
		errors = 0;
		timing_errors = 0;
		for (int i = 0; i < 2048; i++) begin
			ref_img[i] = '0;
		end
		void'($urandom(32'h812d_d55d));

		repeat (2) @(posedge clk_root);
		reset_window <= 1'b1;
		repeat (3) @(posedge clk_root);
		arst_n <= 1'b1;
		repeat (4) @(posedge clk_root);
		reset_window <= 1'b0;
		@(posedge clk_root);
		end_test(1, "reset state", 0);

		err_start = errors;
		for (int i = 0; i < 4; i++) begin
			row = ROW_SET[i*4 +: 4];
			send_line({1'b0, row});
			send_line({1'b1, row});
		end
		wait_frame();
		end_test(2, "line write and display", err_start);

		err_start = errors;
		send_setting(8'h42, 8'($urandom));
		send_setting(8'h43, 8'($urandom));
		wait_frame();
		end_test(3, "brightness and channel enables", err_start);

		err_start = errors;
		send_aborts();
		wait_frame();
		// All planes and channels back on for the re-check
		send_setting(8'h42, 8'h3F);
		send_setting(8'h43, 8'h07);
		wait_frame();
		end_test(4, "command counting and aborts", err_start);

		$display("test 5 panel timing: %s, %0d errors",
			(timing_errors == 0) ? "ok" : "failed", timing_errors);

		if (pixel_checks == 0) begin
			errors++;
			$display("No pixel was compared against the reference image");
		end
		$display("tests 5, errors %0d, pixel checks %0d, latches %0d",
			errors, pixel_checks, latch_count);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(LIMIT_NS);
		$display("Watchdog expired after %0d ns, the run stopped making progress", LIMIT_NS);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+source
source/led_matrix_pkg.sv
source/serial_rx.sv
source/command_parser.sv
source/frame_buffer.sv
source/pixel_fetch.sv
source/matrix_scan.sv
source/led_matrix_top.sv
bench/led_matrix_tb.sv

// ==== source/command_parser.sv ====
// Command decoder for 'L', 'B' and 'C'; bad commands are dropped silently, no error flag
`timescale 1ns/1ps
`default_nettype none
`include "led_matrix_macros.svh"

module command_parser (
	input  wire                          clk_root,
	input  wire                          arst_n,
	input  wire  [7:0]                   rx_byte,
	input  wire                          rx_valid,
	output led_matrix_pkg::fb_write_t    fb_wr,
	output led_matrix_pkg::display_cfg_t cfg,
	output logic                         rx_busy,
	output logic [7:0]                   commands_done
);

	localparam int LINE_BYTES = `LM_COLUMNS * 2;
	localparam int BYTE_W = $clog2(LINE_BYTES);
	localparam int LINE_W = $clog2(`LM_LINES);
	localparam logic [BYTE_W-1:0] BYTE_LAST = BYTE_W'(LINE_BYTES - 1);

	// ASCII command bytes
	localparam logic [7:0] CMD_LINE = 8'h4C;
	localparam logic [7:0] CMD_BRIGHT = 8'h42;
	localparam logic [7:0] CMD_CHAN = 8'h43;

	typedef enum logic [2:0] {S_IDLE, S_LINE, S_DATA, S_BRIGHT, S_CHAN} state_t;

	state_t            state;
	logic [LINE_W-1:0] line_q;
	logic [BYTE_W-1:0] byte_cnt;
	logic              wr_strobe;
	logic [11:0]       wr_addr;
	logic [7:0]        wr_data;
	logic [5:0]        bright_q;
	logic [2:0]        rgb_q;
	logic [7:0]        done_q;

	always_ff @(posedge clk_root or negedge arst_n) begin
		if (!arst_n) begin
			state     <= S_IDLE;
			line_q    <= '0;
			byte_cnt  <= '0;
			wr_strobe <= 1'b0;
			// Everything lit after reset
			bright_q  <= '1;
			rgb_q     <= '1;
			done_q    <= '0;
		end else begin
			wr_strobe <= 1'b0;
			if (rx_valid) begin
				case (state)
					S_IDLE: begin
						// Unknown bytes stay here and are not counted
						case (rx_byte)
							CMD_LINE:   state <= S_LINE;
							CMD_BRIGHT: state <= S_BRIGHT;
							CMD_CHAN:   state <= S_CHAN;
							default:    state <= S_IDLE;
						endcase
					end
					S_LINE: begin
						// Out of range line aborts the command
						if (rx_byte < 8'(`LM_LINES)) begin
							line_q   <= rx_byte[LINE_W-1:0];
							byte_cnt <= '0;
							state    <= S_DATA;
						end else begin
							state <= S_IDLE;
						end
					end
					S_DATA: begin
						wr_strobe <= 1'b1;
						byte_cnt  <= byte_cnt + 1'b1;
						if (byte_cnt == BYTE_LAST) begin
							done_q <= done_q + 1'b1;
							state  <= S_IDLE;
						end
					end
					S_BRIGHT: begin
						bright_q <= rx_byte[5:0];
						done_q   <= done_q + 1'b1;
						state    <= S_IDLE;
					end
					default: begin
						rgb_q  <= rx_byte[2:0];
						done_q <= done_q + 1'b1;
						state  <= S_IDLE;
					end
				endcase
			end
		end
	end

	// Byte address is line * 128 + byte index
	always_ff @(posedge clk_root) begin
		if (rx_valid && state == S_DATA) begin
			wr_addr <= {line_q, byte_cnt};
			wr_data <= rx_byte;
		end
	end

	assign fb_wr = '{we: wr_strobe, addr: wr_addr, data: wr_data};
	assign cfg = '{brightness_enable: bright_q, rgb_enable: rgb_q};
	assign rx_busy = (state != S_IDLE);
	assign commands_done = done_q;

	// Each write follows a received byte and stays inside line 31
	assert property (@(posedge clk_root) disable iff (!arst_n)
		fb_wr.we |-> $past(rx_valid) && fb_wr.addr <= 12'(`LM_LINES * LINE_BYTES - 1));

endmodule

`default_nettype wire

// ==== source/frame_buffer.sv ====
// Dual-port frame store, byte writes on port A and registered pixel reads on port B
`timescale 1ns/1ps
`default_nettype none
`include "led_matrix_macros.svh"

module frame_buffer (
	input  wire                       clk_root,
	input  led_matrix_pkg::fb_write_t fb_wr,
	input  wire  [10:0]               rd_addr,
	output led_matrix_pkg::rgb565_t   rd_data
);

	localparam int WORDS = `LM_LINES * `LM_COLUMNS;

	// Even byte address lands in the high half
	logic [7:0] mem_hi [WORDS];
	logic [7:0] mem_lo [WORDS];

	// Byte write port
	always_ff @(posedge clk_root) begin
		if (fb_wr.we) begin
			if (fb_wr.addr[0]) begin
				mem_lo[fb_wr.addr[11:1]] <= fb_wr.data;
			end else begin
				mem_hi[fb_wr.addr[11:1]] <= fb_wr.data;
			end
		end
	end

	// Pixel read port
	// One cycle latency, reads every cycle
	always_ff @(posedge clk_root) begin
		rd_data <= led_matrix_pkg::rgb565_t'({mem_hi[rd_addr], mem_lo[rd_addr]});
	end

endmodule

`default_nettype wire

// ==== source/led_matrix_macros.svh ====
// Panel geometry and timing constants, sized for a 64x32 panel scanned as 16 row pairs
`ifndef LED_MATRIX_MACROS_SVH
`define LED_MATRIX_MACROS_SVH

// Pixels per panel line
`define LM_COLUMNS 64

// Physical panel lines
`define LM_LINES 32

// Lines driven at once, top and bottom half
`define LM_ROW_PAIRS 16

// Brightness bit planes per row pair
`define LM_PLANES 6

// Serial bit period in clk_root cycles
// 21 cycles per bit, sampled at mid-bit
`define LM_UART_TICKS_PER_BIT 21

// Scan tick period in clk_root cycles
`define LM_SCAN_DIV 2

// Lit time of plane 0
// Doubles for every higher plane
`define LM_OE_BASE_CYCLES 8

`endif

// ==== source/led_matrix_pkg.sv ====
// Shared packed structs, field widths fixed for a 64x32 panel with 6 planes
`default_nettype none

package led_matrix_pkg;

	// One frame buffer pixel
	// Red in the top bits
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	// Byte write into the frame buffer
	// Address is line * 128 + byte index
	typedef struct packed {
		logic        we;
		logic [11:0] addr;
		logic [7:0]  data;
	} fb_write_t;

	// Plane and colour gating
	// rgb_enable bit 0 red, bit 1 green, bit 2 blue
	typedef struct packed {
		logic [5:0] brightness_enable;
		logic [2:0] rgb_enable;
	} display_cfg_t;

	// Scan to fetch request
	typedef struct packed {
		logic       strobe;
		logic [3:0] row_pair;
		logic [5:0] column;
		logic [2:0] plane;
	} pixel_req_t;

	// Fetch result, same colour order as rgb_enable
	typedef struct packed {
		logic [2:0] rgb_top;
		logic [2:0] rgb_bot;
		logic       valid;
	} plane_bits_t;

	// HUB75 panel pins
	typedef struct packed {
		logic [3:0] row_addr;
		logic [2:0] rgb_top;
		logic [2:0] rgb_bot;
		logic       pixel_clk;
		logic       latch;
		logic       oe_n;
	} hub75_t;

endpackage

`default_nettype wire

// ==== source/led_matrix_top.sv ====
// LED matrix subsystem top; no PLL, panel init or reset synchroniser, arst_n used as given
`timescale 1ns/1ps
`default_nettype none

module led_matrix_top (
	input  wire                    clk_root,
	input  wire                    arst_n,
	input  wire                    rxd,
	output led_matrix_pkg::hub75_t panel,
	output logic                   rx_busy,
	output logic [7:0]             commands_done
);

	// Serial bytes into the parser
	logic [7:0]                   rx_byte;
	logic                         rx_valid;

	// Write side of the frame buffer and display settings
	led_matrix_pkg::fb_write_t    fb_wr;
	led_matrix_pkg::display_cfg_t cfg;

	// Read side, scan to fetch to RAM
	logic [10:0]                  rd_addr;
	led_matrix_pkg::rgb565_t      rd_data;
	led_matrix_pkg::pixel_req_t   req;
	led_matrix_pkg::plane_bits_t  bits;

	serial_rx serial_rx_inst (
		.clk_root (clk_root),
		.arst_n   (arst_n),
		.rxd      (rxd),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid)
	);

	command_parser command_parser_inst (
		.clk_root      (clk_root),
		.arst_n        (arst_n),
		.rx_byte       (rx_byte),
		.rx_valid      (rx_valid),
		.fb_wr         (fb_wr),
		.cfg           (cfg),
		.rx_busy       (rx_busy),
		.commands_done (commands_done)
	);

	frame_buffer frame_buffer_inst (
		.clk_root (clk_root),
		.fb_wr    (fb_wr),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

	pixel_fetch pixel_fetch_inst (
		.clk_root (clk_root),
		.arst_n   (arst_n),
		.req      (req),
		.cfg      (cfg),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.bits     (bits)
	);

	matrix_scan matrix_scan_inst (
		.clk_root (clk_root),
		.arst_n   (arst_n),
		.req      (req),
		.bits     (bits),
		.panel    (panel)
	);

endmodule

`default_nettype wire

// ==== source/matrix_scan.sv ====
// HUB75 scan sequencer on clk_root with a tick enable; one pixel request in flight at a time
`timescale 1ns/1ps
`default_nettype none
`include "led_matrix_macros.svh"

module matrix_scan (
	input  wire                         clk_root,
	input  wire                         arst_n,
	output led_matrix_pkg::pixel_req_t  req,
	input  led_matrix_pkg::plane_bits_t bits,
	output led_matrix_pkg::hub75_t      panel
);

	localparam int DIV_W = $clog2(`LM_SCAN_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`LM_SCAN_DIV - 1);
	localparam int ON_MAX = `LM_OE_BASE_CYCLES << (`LM_PLANES - 1);
	localparam int ON_W = $clog2(ON_MAX);

	typedef enum logic [2:0] {
		S_REQ, S_WAIT, S_SETUP, S_CLK_HI, S_LATCH, S_LIGHT
	} state_t;

	state_t           state;
	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	logic [5:0]       column;
	logic [2:0]       plane;
	logic [3:0]       row_pair;
	logic [ON_W-1:0]  on_cnt;
	logic             req_strobe;
	logic [3:0]       row_addr_q;
	logic [2:0]       rgb_top_q;
	logic [2:0]       rgb_bot_q;
	logic             pixel_clk_q;
	logic             latch_q;
	logic             oe_n_q;

	// Free running scan tick
	always_ff @(posedge clk_root or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
		end
	end

	assign tick = (div_cnt == DIV_LAST);

	always_ff @(posedge clk_root or negedge arst_n) begin
		if (!arst_n) begin
			state       <= S_REQ;
			column      <= '0;
			plane       <= '0;
			row_pair    <= '0;
			on_cnt      <= '0;
			req_strobe  <= 1'b0;
			row_addr_q  <= '0;
			rgb_top_q   <= '0;
			rgb_bot_q   <= '0;
			pixel_clk_q <= 1'b0;
			latch_q     <= 1'b0;
			// Panel dark until the first plane is latched
			oe_n_q      <= 1'b1;
		end else begin
			req_strobe <= 1'b0;
			case (state)
				S_REQ: begin
					req_strobe <= 1'b1;
					state      <= S_WAIT;
				end
				S_WAIT: begin
					if (bits.valid) begin
						rgb_top_q <= bits.rgb_top;
						rgb_bot_q <= bits.rgb_bot;
						state     <= S_SETUP;
					end
				end
				S_SETUP: begin
					// Data settles before the shift edge
					if (tick) begin
						pixel_clk_q <= 1'b1;
						state       <= S_CLK_HI;
					end
				end
				S_CLK_HI: begin
					if (tick) begin
						pixel_clk_q <= 1'b0;
						if (column == 6'(`LM_COLUMNS - 1)) begin
							column     <= '0;
							latch_q    <= 1'b1;
							row_addr_q <= row_pair;
							state      <= S_LATCH;
						end else begin
							column <= column + 1'b1;
							state  <= S_REQ;
						end
					end
				end
				S_LATCH: begin
					// Latch drops and the row lights on the same edge
					if (tick) begin
						latch_q <= 1'b0;
						oe_n_q  <= 1'b0;
						on_cnt  <= ON_W'((`LM_OE_BASE_CYCLES << plane) - 1);
						state   <= S_LIGHT;
					end
				end
				default: begin
					// On time counted in clk_root cycles, not ticks
					if (on_cnt == '0) begin
						oe_n_q <= 1'b1;
						state  <= S_REQ;
						if (plane == 3'(`LM_PLANES - 1)) begin
							plane    <= '0;
							// Row pair 15 wraps to 0
							row_pair <= row_pair + 1'b1;
						end else begin
							plane <= plane + 1'b1;
						end
					end else begin
						on_cnt <= on_cnt - 1'b1;
					end
				end
			endcase
		end
	end

	assign req = '{strobe: req_strobe, row_pair: row_pair, column: column, plane: plane};

	assign panel = '{
		row_addr: row_addr_q,
		rgb_top: rgb_top_q,
		rgb_bot: rgb_bot_q,
		pixel_clk: pixel_clk_q,
		latch: latch_q,
		oe_n: oe_n_q
	};

	// Never latch into a lit row
	assert property (@(posedge clk_root) disable iff (!arst_n) panel.latch |-> panel.oe_n);

	// Fetch answers every request four cycles later
	assert property (@(posedge clk_root) disable iff (!arst_n) req.strobe |-> ##4 bits.valid);

endmodule

`default_nettype wire

// ==== source/pixel_fetch.sv ====
// Top then bottom pixel fetch with fixed 4-cycle latency; accepts one request at a time
`timescale 1ns/1ps
`default_nettype none
`include "led_matrix_macros.svh"

module pixel_fetch (
	input  wire                          clk_root,
	input  wire                          arst_n,
	input  led_matrix_pkg::pixel_req_t   req,
	input  led_matrix_pkg::display_cfg_t cfg,
	output logic [10:0]                  rd_addr,
	input  led_matrix_pkg::rgb565_t      rd_data,
	output led_matrix_pkg::plane_bits_t  bits
);

	localparam int LINE_W = $clog2(`LM_LINES);

	typedef enum logic [1:0] {F_IDLE, F_ADDR_BOT, F_CAP_BOT, F_APPLY} state_t;

	state_t                  state;
	logic [3:0]              row_q;
	logic [5:0]              col_q;
	logic [2:0]              plane_q;
	led_matrix_pkg::rgb565_t top_q;
	led_matrix_pkg::rgb565_t bot_q;
	logic [2:0]              top_bits_q;
	logic [2:0]              bot_bits_q;
	logic                    valid_q;

	// One pixel to three plane bits
	// Red and blue get a zero below the LSB
	function automatic logic [2:0] reduce_pixel(input led_matrix_pkg::rgb565_t px,
		input logic [2:0] plane, input led_matrix_pkg::display_cfg_t c);
		logic [5:0] red_w;
		logic [5:0] grn_w;
		logic [5:0] blu_w;
		logic       plane_on;
		red_w = {px.red, 1'b0};
		grn_w = px.green;
		blu_w = {px.blue, 1'b0};
		plane_on = c.brightness_enable[plane];
		return {blu_w[plane], grn_w[plane], red_w[plane]} & {3{plane_on}} & c.rgb_enable;
	endfunction

	// Top line straight from the request, bottom line sixteen further down
	always_comb begin
		if (state == F_ADDR_BOT) begin
			rd_addr = {LINE_W'(row_q) + LINE_W'(`LM_ROW_PAIRS), col_q};
		end else begin
			rd_addr = {LINE_W'(req.row_pair), req.column};
		end
	end

	always_ff @(posedge clk_root or negedge arst_n) begin
		if (!arst_n) begin
			state   <= F_IDLE;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state)
				F_IDLE:     if (req.strobe) state <= F_ADDR_BOT;
				F_ADDR_BOT: state <= F_CAP_BOT;
				F_CAP_BOT:  state <= F_APPLY;
				default: begin
					valid_q <= 1'b1;
					state   <= F_IDLE;
				end
			endcase
		end
	end

	// Captured request and pixel data
	always_ff @(posedge clk_root) begin
		if (state == F_IDLE && req.strobe) begin
			row_q   <= req.row_pair;
			col_q   <= req.column;
			plane_q <= req.plane;
		end
		if (state == F_ADDR_BOT) begin
			top_q <= rd_data;
		end
		if (state == F_CAP_BOT) begin
			bot_q <= rd_data;
		end
		if (state == F_APPLY) begin
			top_bits_q <= reduce_pixel(top_q, plane_q, cfg);
			bot_bits_q <= reduce_pixel(bot_q, plane_q, cfg);
		end
	end

	assign bits = '{rgb_top: top_bits_q, rgb_bot: bot_bits_q, valid: valid_q};

	// Scan side must wait for valid before asking again
	assert property (@(posedge clk_root) disable iff (!arst_n) req.strobe |-> state == F_IDLE);

endmodule

`default_nettype wire

// ==== source/serial_rx.sv ====
// 8N1 receiver at a fixed bit period; no parity, frames with a low stop bit are dropped
`timescale 1ns/1ps
`default_nettype none
`include "led_matrix_macros.svh"

module serial_rx (
	input  wire        clk_root,
	input  wire        arst_n,
	input  wire        rxd,
	output logic [7:0] rx_byte,
	output logic       rx_valid
);

	localparam int TICKS = `LM_UART_TICKS_PER_BIT;
	localparam int CNT_W = $clog2(TICKS);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(TICKS - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(TICKS / 2 - 1);

	typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

	state_t           state;
	logic             rxd_meta;
	logic             rxd_sync;
	logic [CNT_W-1:0] tick_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift;
	logic             sample_bit;

	// Mid-bit point of a data bit
	assign sample_bit = (state == S_DATA) && (tick_cnt == BIT_LAST);

	always_ff @(posedge clk_root or negedge arst_n) begin
		if (!arst_n) begin
			// Line idles high
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			state    <= S_IDLE;
			tick_cnt <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rx_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					// Falling edge starts a frame
					if (!rxd_sync) begin
						tick_cnt <= '0;
						state    <= S_START;
					end
				end
				S_START: begin
					if (tick_cnt == HALF_LAST) begin
						tick_cnt <= '0;
						bit_idx  <= '0;
						// Start bit gone high at mid-bit is a glitch
						state    <= rxd_sync ? S_IDLE : S_DATA;
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (sample_bit) begin
						tick_cnt <= '0;
						bit_idx  <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= S_STOP;
						end
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				default: begin
					if (tick_cnt == BIT_LAST) begin
						state    <= S_IDLE;
						// Framing check
						rx_valid <= rxd_sync;
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// LSB first
	always_ff @(posedge clk_root) begin
		if (sample_bit) begin
			shift <= {rxd_sync, shift[7:1]};
		end
	end

	assign rx_byte = shift;

	// A frame lasts ten bit times, so strobes are far apart
	assert property (@(posedge clk_root) disable iff (!arst_n) rx_valid |=> !rx_valid);

endmodule

`default_nettype wire
